//--- verilog/ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// Dispatch side
`define N_DISPATCH 2        // Allocation lanes per cycle

// Station and execute side
`define RS_SZ      8        // Reservation station entries
`define NUM_FU     2        // ALUs, one CDB lane each

// Widths
`define TAG_W      5        // Producer tag
`define DATA_W     32       // Operand and result data

`endif

//--- verilog/isa_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Instruction-side encodings shared by dispatch, station and ALUs
////////////////////////////////////////////////////////////////////////////

package isa_pkg;

    // ALU opcodes, 3 bit encoding
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,     // a + b
        ALU_SUB = 3'd1,     // a - b
        ALU_AND = 3'd2,     // a & b
        ALU_OR  = 3'd3,     // a | b
        ALU_XOR = 3'd4,     // a ^ b
        ALU_SLL = 3'd5      // a << b[4:0]
    } alu_op_e;

    // How a source operand arrives at dispatch
    typedef enum logic {
        SRC_VALUE = 1'b0,   // Value already known
        SRC_TAG   = 1'b1    // Waits on a producer tag
    } src_kind_e;

endpackage

`default_nettype wire

//--- verilog/rs_pkg.sv
`default_nettype none

`include "ooo_settings.svh"

////////////////////////////////////////////////////////////////////////////
// Reservation station storage types
////////////////////////////////////////////////////////////////////////////

package rs_pkg;

    import isa_pkg::*;

    // One station entry, 85 bits packed
    typedef struct packed {
        logic                 valid;       // Slot holds an instruction
        alu_op_e              op;          // ALU operation
        // Source 1
        logic [`TAG_W-1:0]    src1_tag;    // Producer tag when waiting
        logic                 src1_ready;  // Value captured
        logic [`DATA_W-1:0]   src1_value;
        // Source 2
        logic [`TAG_W-1:0]    src2_tag;
        logic                 src2_ready;
        logic [`DATA_W-1:0]   src2_value;
        // Result
        logic [`TAG_W-1:0]    dest_tag;    // Tag broadcast on completion
    } rs_entry_t;

    // Slot index into the station
    typedef logic [$clog2(`RS_SZ)-1:0] rs_idx_t;

endpackage

`default_nettype wire

//--- verilog/rs_free_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

// Two-ended free slot picker for the allocation lanes
module rs_free_select
    import rs_pkg::*;
(
    input  wire logic [`RS_SZ-1:0] free_mask,   // 1 = slot free
    output logic      [`RS_SZ-1:0] grant_lo,    // Lane 0 slot, one-hot
    output logic      [`RS_SZ-1:0] grant_hi,    // Lane 1 slot, one-hot
    output logic                   lo_found,
    output logic                   hi_found
);

    rs_idx_t lo_idx;
    rs_idx_t hi_idx;
    logic    hi_any;                            // Some free slot seen from the top

    // Lowest free slot
    always_comb begin
        lo_found = 1'b0;
        lo_idx   = '0;
        for (int i = 0; i < `RS_SZ; i++) begin
            if (free_mask[i] && !lo_found) begin
                lo_found = 1'b1;
                lo_idx   = rs_idx_t'(i);
            end
        end
    end

    // Highest free slot
    always_comb begin
        hi_any = 1'b0;
        hi_idx = '0;
        for (int i = `RS_SZ - 1; i >= 0; i--) begin
            if (free_mask[i] && !hi_any) begin
                hi_any = 1'b1;
                hi_idx = rs_idx_t'(i);
            end
        end
    end

    // Only one free slot means both scans land on it, lane 1 gets nothing
    assign hi_found = hi_any && (hi_idx != lo_idx);

    always_comb begin
        grant_lo         = '0;
        grant_hi         = '0;
        grant_lo[lo_idx] = lo_found;
        grant_hi[hi_idx] = hi_found;
    end

endmodule

`default_nettype wire

//--- verilog/rs.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

// Reservation station: allocate, wake on CDB, clear on issue
module rs
    import isa_pkg::*, rs_pkg::*;
(
    input  wire logic                                 clock,
    input  wire logic                                 rst_n,
    input  wire logic                                 flush,        // Mispredict, empty all
    // Dispatch lanes
    input  wire logic    [`N_DISPATCH-1:0]                 alloc_valid,
    input  wire alu_op_e [`N_DISPATCH-1:0]                 alloc_op,
    input  wire logic    [`N_DISPATCH-1:0][`TAG_W-1:0]     alloc_dest_tag,
    input  wire logic    [`N_DISPATCH-1:0]                 alloc_src1_ready,
    input  wire logic    [`N_DISPATCH-1:0][`TAG_W-1:0]     alloc_src1_tag,
    input  wire logic    [`N_DISPATCH-1:0][`DATA_W-1:0]    alloc_src1_value,
    input  wire logic    [`N_DISPATCH-1:0]                 alloc_src2_ready,
    input  wire logic    [`N_DISPATCH-1:0][`TAG_W-1:0]     alloc_src2_tag,
    input  wire logic    [`N_DISPATCH-1:0][`DATA_W-1:0]    alloc_src2_value,
    // Issue clears
    input  wire logic    [`NUM_FU-1:0]                     clear_valid,
    input  wire rs_idx_t [`NUM_FU-1:0]                     clear_idx,
    // CDB wakeup
    input  wire logic    [`NUM_FU-1:0]                     cdb_valid,
    input  wire logic    [`NUM_FU-1:0][`TAG_W-1:0]         cdb_tag,
    input  wire logic    [`NUM_FU-1:0][`DATA_W-1:0]        cdb_value,
    // To issue and dispatch
    output rs_entry_t    [`RS_SZ-1:0]                      entries,
    output logic         [$clog2(`N_DISPATCH+1)-1:0]       free_count
);

    localparam int CNT_W = $clog2(`RS_SZ + 1);
    localparam int FC_W  = $clog2(`N_DISPATCH + 1);

    rs_entry_t [`RS_SZ-1:0]                   rs_array;
    rs_entry_t [`RS_SZ-1:0]                   rs_array_next;
    logic      [`RS_SZ-1:0]                   free_mask;
    logic      [`N_DISPATCH-1:0][`RS_SZ-1:0]  lane_grant;   // One-hot slot per lane
    logic      [`N_DISPATCH-1:0]              lane_found;
    logic      [`N_DISPATCH-1:0]              alloc_take;   // Lane actually written
    logic      [CNT_W-1:0]                    free_slots;
    logic      [CNT_W-1:0]                    free_slots_next;

    ////////////////////////////////////////////////////////////////////////////
    // Free slot selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `RS_SZ; i++) begin
            free_mask[i] = !rs_array[i].valid;
        end
    end

    rs_free_select i_rs_free_select (
        .free_mask (free_mask),
        .grant_lo  (lane_grant[0]),       // Lane 0 from the bottom
        .grant_hi  (lane_grant[1]),       // Lane 1 from the top
        .lo_found  (lane_found[0]),
        .hi_found  (lane_found[1])
    );

    // Lanes beyond the free slots are dropped
    assign alloc_take = alloc_valid & lane_found;

    ////////////////////////////////////////////////////////////////////////////
    // Next state: clear, allocate, then wake
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rs_array_next = rs_array;

        // Issued slots leave
        for (int f = 0; f < `NUM_FU; f++) begin
            if (clear_valid[f]) rs_array_next[clear_idx[f]].valid = 1'b0;
        end

        // Write granted allocations
        for (int l = 0; l < `N_DISPATCH; l++) begin
            for (int j = 0; j < `RS_SZ; j++) begin
                if (alloc_take[l] && lane_grant[l][j]) begin
                    rs_array_next[j].valid      = 1'b1;
                    rs_array_next[j].op         = alloc_op[l];
                    rs_array_next[j].src1_tag   = alloc_src1_tag[l];
                    rs_array_next[j].src1_ready = alloc_src1_ready[l];
                    rs_array_next[j].src1_value = alloc_src1_value[l];
                    rs_array_next[j].src2_tag   = alloc_src2_tag[l];
                    rs_array_next[j].src2_ready = alloc_src2_ready[l];
                    rs_array_next[j].src2_value = alloc_src2_value[l];
                    rs_array_next[j].dest_tag   = alloc_dest_tag[l];
                end
            end
        end

        // Tag match on every lane, new allocations included
        for (int i = 0; i < `RS_SZ; i++) begin
            for (int c = 0; c < `NUM_FU; c++) begin
                if (rs_array_next[i].valid && cdb_valid[c]) begin
                    if (!rs_array_next[i].src1_ready &&
                        rs_array_next[i].src1_tag == cdb_tag[c]) begin
                        rs_array_next[i].src1_ready = 1'b1;
                        rs_array_next[i].src1_value = cdb_value[c];   // Capture result
                    end
                    if (!rs_array_next[i].src2_ready &&
                        rs_array_next[i].src2_tag == cdb_tag[c]) begin
                        rs_array_next[i].src2_ready = 1'b1;
                        rs_array_next[i].src2_value = cdb_value[c];
                    end
                end
            end
        end
    end

    // Running free count, clears add and accepted allocations subtract
    always_comb begin
        free_slots_next = free_slots;
        for (int f = 0; f < `NUM_FU; f++) begin
            if (clear_valid[f]) free_slots_next = free_slots_next + 1'b1;
        end
        for (int l = 0; l < `N_DISPATCH; l++) begin
            if (alloc_take[l]) free_slots_next = free_slots_next - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < `RS_SZ; i++) begin
                rs_array[i].valid <= 1'b0;          // Payload left as is
            end
            free_slots <= CNT_W'(`RS_SZ);
        end else begin
            rs_array   <= rs_array_next;
            free_slots <= free_slots_next;
        end
    end

    assign entries    = rs_array;
    assign free_count = (free_slots > CNT_W'(`N_DISPATCH)) ? FC_W'(`N_DISPATCH)
                                                           : FC_W'(free_slots);

endmodule

`default_nettype wire

//--- verilog/issue_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

// Picks two ready entries and feeds their operands to the ALUs
module issue_select
    import isa_pkg::*, rs_pkg::*;
(
    input  wire rs_entry_t [`RS_SZ-1:0]               entries,
    // ALU requests
    output logic           [`NUM_FU-1:0]              fu_valid,
    output alu_op_e        [`NUM_FU-1:0]              fu_op,
    output logic           [`NUM_FU-1:0][`DATA_W-1:0] fu_a,
    output logic           [`NUM_FU-1:0][`DATA_W-1:0] fu_b,
    output logic           [`NUM_FU-1:0][`TAG_W-1:0]  fu_dest_tag,
    // Back to the station
    output logic           [`NUM_FU-1:0]              clear_valid,
    output rs_idx_t        [`NUM_FU-1:0]              clear_idx
);

    logic    [`RS_SZ-1:0]  ready_mask;
    logic                  lo_found;
    logic                  hi_any;
    rs_idx_t               lo_idx;
    rs_idx_t               hi_idx;
    rs_idx_t [`NUM_FU-1:0] sel_idx;        // Chosen slot per ALU

    always_comb begin
        for (int i = 0; i < `RS_SZ; i++) begin
            ready_mask[i] = entries[i].valid && entries[i].src1_ready &&
                            entries[i].src2_ready;
        end
    end

    // ALU 0 scans upward, ALU 1 downward
    always_comb begin
        lo_found = 1'b0;
        lo_idx   = '0;
        hi_any   = 1'b0;
        hi_idx   = '0;
        for (int i = 0; i < `RS_SZ; i++) begin
            if (ready_mask[i] && !lo_found) begin
                lo_found = 1'b1;
                lo_idx   = rs_idx_t'(i);
            end
        end
        for (int i = `RS_SZ - 1; i >= 0; i--) begin
            if (ready_mask[i] && !hi_any) begin
                hi_any = 1'b1;
                hi_idx = rs_idx_t'(i);
            end
        end
    end

    assign fu_valid[0] = lo_found;
    assign fu_valid[1] = hi_any && (hi_idx != lo_idx);  // Single ready entry goes to ALU 0
    assign sel_idx[0]  = lo_idx;
    assign sel_idx[1]  = hi_idx;

    // Operands straight from the registered entries
    always_comb begin
        for (int f = 0; f < `NUM_FU; f++) begin
            fu_op[f]       = entries[sel_idx[f]].op;
            fu_a[f]        = entries[sel_idx[f]].src1_value;
            fu_b[f]        = entries[sel_idx[f]].src2_value;
            fu_dest_tag[f] = entries[sel_idx[f]].dest_tag;
            clear_valid[f] = fu_valid[f];
            clear_idx[f]   = sel_idx[f];
        end
    end

endmodule

`default_nettype wire

//--- verilog/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

// Single-cycle ALU, result registered onto one CDB lane
module alu_unit
    import isa_pkg::*;
(
    input  wire logic                clock,
    input  wire logic                rst_n,
    input  wire logic                flush,
    // From issue
    input  wire logic                fu_valid,
    input  wire alu_op_e             fu_op,
    input  wire logic [`DATA_W-1:0]  fu_a,
    input  wire logic [`DATA_W-1:0]  fu_b,
    input  wire logic [`TAG_W-1:0]   fu_dest_tag,
    // CDB lane
    output logic                     cdb_valid,
    output logic      [`TAG_W-1:0]   cdb_tag,
    output logic      [`DATA_W-1:0]  cdb_value
);

    localparam int SH_W = $clog2(`DATA_W);

    logic [`DATA_W-1:0] result;

    ////////////////////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (fu_op)
            ALU_ADD: result = fu_a + fu_b;
            ALU_SUB: result = fu_a - fu_b;
            ALU_AND: result = fu_a & fu_b;
            ALU_OR:  result = fu_a | fu_b;
            ALU_XOR: result = fu_a ^ fu_b;
            ALU_SLL: result = fu_a << fu_b[SH_W-1:0];  // Low bits only
            default: result = '0;                      // Unused encodings
        endcase
    end

    // Broadcast register
    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            cdb_valid <= 1'b0;                         // Drops result in flight
        end else begin
            cdb_valid <= fu_valid;
        end
        cdb_tag   <= fu_dest_tag;
        cdb_value <= result;
    end

endmodule

`default_nettype wire

//--- verilog/ooo_issue_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

// Issue stage top: station, issue selector, two ALUs on a two-lane CDB
module ooo_issue_core
    import isa_pkg::*, rs_pkg::*;
(
    input  wire logic                                 clock,
    input  wire logic                                 rst_n,
    input  wire logic                                 flush,
    // Dispatch lanes
    input  wire logic    [`N_DISPATCH-1:0]                 alloc_valid,
    input  wire alu_op_e [`N_DISPATCH-1:0]                 alloc_op,
    input  wire logic    [`N_DISPATCH-1:0][`TAG_W-1:0]     alloc_dest_tag,
    input  wire logic    [`N_DISPATCH-1:0]                 alloc_src1_ready,
    input  wire logic    [`N_DISPATCH-1:0][`TAG_W-1:0]     alloc_src1_tag,
    input  wire logic    [`N_DISPATCH-1:0][`DATA_W-1:0]    alloc_src1_value,
    input  wire logic    [`N_DISPATCH-1:0]                 alloc_src2_ready,
    input  wire logic    [`N_DISPATCH-1:0][`TAG_W-1:0]     alloc_src2_tag,
    input  wire logic    [`N_DISPATCH-1:0][`DATA_W-1:0]    alloc_src2_value,
    output logic         [$clog2(`N_DISPATCH+1)-1:0]       free_count,
    // Common data bus
    output logic         [`NUM_FU-1:0]                     cdb_valid,
    output logic         [`NUM_FU-1:0][`TAG_W-1:0]         cdb_tag,
    output logic         [`NUM_FU-1:0][`DATA_W-1:0]        cdb_value
);

    rs_entry_t [`RS_SZ-1:0]               entries;
    logic      [`NUM_FU-1:0]              clear_valid;
    rs_idx_t   [`NUM_FU-1:0]              clear_idx;
    logic      [`NUM_FU-1:0]              fu_valid;
    alu_op_e   [`NUM_FU-1:0]              fu_op;
    logic      [`NUM_FU-1:0][`DATA_W-1:0] fu_a;
    logic      [`NUM_FU-1:0][`DATA_W-1:0] fu_b;
    logic      [`NUM_FU-1:0][`TAG_W-1:0]  fu_dest_tag;

    rs i_rs (
        .clock, .rst_n, .flush,
        .alloc_valid, .alloc_op, .alloc_dest_tag,
        .alloc_src1_ready, .alloc_src1_tag, .alloc_src1_value,
        .alloc_src2_ready, .alloc_src2_tag, .alloc_src2_value,
        .clear_valid, .clear_idx,
        .cdb_valid, .cdb_tag, .cdb_value,   // Wakeup from our own bus
        .entries, .free_count
    );

    issue_select i_issue_select (
        .entries,
        .fu_valid, .fu_op, .fu_a, .fu_b, .fu_dest_tag,
        .clear_valid, .clear_idx
    );

    // One ALU per bus lane
    for (genvar f = 0; f < `NUM_FU; f++) begin : g_alu
        alu_unit i_alu_unit (
            .clock       (clock),
            .rst_n       (rst_n),
            .flush       (flush),
            .fu_valid    (fu_valid[f]),
            .fu_op       (fu_op[f]),
            .fu_a        (fu_a[f]),
            .fu_b        (fu_b[f]),
            .fu_dest_tag (fu_dest_tag[f]),
            .cdb_valid   (cdb_valid[f]),
            .cdb_tag     (cdb_tag[f]),
            .cdb_value   (cdb_value[f])
        );
    end

endmodule

`default_nettype wire

//--- test/tb_ooo_issue_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module tb_ooo_issue_core
    import isa_pkg::*;
();

    localparam int NTAG    = 1 << `TAG_W;
    localparam int TMO     = 200;          // Cycles allowed per wait
    localparam int ST_FREE = 0;            // Tag may be handed out
    localparam int ST_OUT  = 1;            // Dispatched with result pending
    localparam int ST_DROP = 2;            // Lost to a flush

    logic                                 clock;
    logic                                 rst_n;
    logic                                 flush;
    logic    [`N_DISPATCH-1:0]              alloc_valid;
    alu_op_e [`N_DISPATCH-1:0]              alloc_op;
    logic    [`N_DISPATCH-1:0][`TAG_W-1:0]  alloc_dest_tag;
    logic    [`N_DISPATCH-1:0]              alloc_src1_ready;
    logic    [`N_DISPATCH-1:0][`TAG_W-1:0]  alloc_src1_tag;
    logic    [`N_DISPATCH-1:0][`DATA_W-1:0] alloc_src1_value;
    logic    [`N_DISPATCH-1:0]              alloc_src2_ready;
    logic    [`N_DISPATCH-1:0][`TAG_W-1:0]  alloc_src2_tag;
    logic    [`N_DISPATCH-1:0][`DATA_W-1:0] alloc_src2_value;
    logic    [$clog2(`N_DISPATCH+1)-1:0]    free_count;
    logic    [`NUM_FU-1:0]                  cdb_valid;
    logic    [`NUM_FU-1:0][`TAG_W-1:0]      cdb_tag;
    logic    [`NUM_FU-1:0][`DATA_W-1:0]     cdb_value;

    // Reference model indexed by destination tag
    logic [`DATA_W-1:0] exp_val [NTAG];
    int                 tag_state [NTAG];
    int                 next_tag;              // Round-robin start for tag search
    int                 n_disp;
    int                 n_drop;
    int                 n_bcast;
    int                 recent [$];            // Last few destination tags
    integer             seed;

    ooo_issue_core i_ooo_issue_core (
        .clock, .rst_n, .flush,
        .alloc_valid, .alloc_op, .alloc_dest_tag,
        .alloc_src1_ready, .alloc_src1_tag, .alloc_src1_value,
        .alloc_src2_ready, .alloc_src2_tag, .alloc_src2_value,
        .free_count,
        .cdb_valid, .cdb_tag, .cdb_value
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;             // 20 ns period

    ////////////////////////////////////////////////////////////////////////////
    // Model and helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [`DATA_W-1:0] alu_model(alu_op_e op, logic [`DATA_W-1:0] a,
                                                     logic [`DATA_W-1:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[$clog2(`DATA_W)-1:0];   // Shift by low 5 bits
            default: return '0;
        endcase
    endfunction

    function automatic int rnd(int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic int count_state(int s);
        int cnt;
        cnt = 0;
        for (int i = 0; i < NTAG; i++) begin
            if (tag_state[i] == s) cnt++;
        end
        return cnt;
    endfunction

    // Producer tag for a random source or -1 for an immediate value
    function automatic int pick_src();
        if (recent.size() == 0 || rnd(2) == 0) return -1;
        return recent[rnd(recent.size())];
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic step();
        @(posedge clock);
        #1;                                // Drive point after the edge
    endtask

    task automatic take_tag(output int t);
        int idx;
        t = -1;
        for (int i = 0; i < NTAG; i++) begin
            idx = (next_tag + i) % NTAG;
            if (t < 0 && tag_state[idx] == ST_FREE) t = idx;
        end
        assert (t >= 0) else fail_run("No free destination tag left");
        next_tag = (t + 1) % NTAG;
    endtask

    task automatic wait_space(int n);
        int cnt;
        cnt = 0;
        while (free_count < n || count_state(ST_FREE) < n) begin
            step();
            cnt++;
            assert (cnt < TMO) else fail_run("Timeout waiting for free station slots");
        end
    endtask

    // Source either waits on an outstanding producer or carries a value
    task automatic make_src(input int p, input logic [`DATA_W-1:0] v, output logic rdy,
                            output logic [`TAG_W-1:0] tg, output logic [`DATA_W-1:0] val,
                            output logic [`DATA_W-1:0] model);
        rdy   = 1'b1;
        tg    = '0;
        val   = v;
        model = v;
        if (p >= 0) begin
            model = exp_val[p];
            val   = exp_val[p];
            if (tag_state[p] == ST_OUT) begin
                rdy = 1'b0;                // Woken from the bus even in the broadcast cycle
                tg  = p[`TAG_W-1:0];
                val = '0;
            end
        end
    endtask

    task automatic stage_lane(int l, alu_op_e op, int p1, logic [`DATA_W-1:0] v1,
                              int p2, logic [`DATA_W-1:0] v2, int dest);
        logic               r1;
        logic               r2;
        logic [`TAG_W-1:0]  t1;
        logic [`TAG_W-1:0]  t2;
        logic [`DATA_W-1:0] s1;
        logic [`DATA_W-1:0] s2;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        make_src(p1, v1, r1, t1, s1, a);
        make_src(p2, v2, r2, t2, s2, b);
        alloc_valid[l]      = 1'b1;
        alloc_op[l]         = op;
        alloc_dest_tag[l]   = dest[`TAG_W-1:0];
        alloc_src1_ready[l] = r1;
        alloc_src1_tag[l]   = t1;
        alloc_src1_value[l] = s1;
        alloc_src2_ready[l] = r2;
        alloc_src2_tag[l]   = t2;
        alloc_src2_value[l] = s2;
        exp_val[dest]       = alu_model(op, a, b);
        tag_state[dest]     = ST_OUT;
        n_disp++;
    endtask

    task automatic commit();
        step();                            // Allocation edge
        alloc_valid = '0;
    endtask

    task automatic dispatch_one(alu_op_e op, int p1, logic [`DATA_W-1:0] v1,
                                int p2, logic [`DATA_W-1:0] v2, output int t);
        wait_space(1);
        take_tag(t);
        stage_lane(0, op, p1, v1, p2, v2, t);
        commit();
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while (count_state(ST_OUT) != 0) begin
            step();
            cnt++;
            assert (cnt < TMO) else fail_run("Timeout waiting for outstanding results");
        end
    endtask

    task automatic wait_on_bus(int t);
        int cnt;
        cnt = 0;
        while (!(cdb_valid[0] && cdb_tag[0] == t) && !(cdb_valid[1] && cdb_tag[1] == t)) begin
            step();
            cnt++;
            assert (cnt < TMO) else fail_run("Timeout waiting for a tag on the bus");
        end
    endtask

    task automatic wait_free_count(int n);
        int cnt;
        cnt = 0;
        while (free_count != n) begin
            step();
            cnt++;
            assert (cnt < TMO) else fail_run("Timeout waiting for free_count to settle");
        end
    endtask

    task automatic check_free_count(int n);
        assert (free_count == n) else
            fail_run($sformatf("** Error: free_count = 0x%0h, expected 0x%0h", free_count, n));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus monitor sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (rst_n) begin
            for (int c = 0; c < `NUM_FU; c++) begin
                if (cdb_valid[c]) begin
                    assert (tag_state[cdb_tag[c]] == ST_OUT) else
                        fail_run($sformatf("Tag 0x%02h broadcast on lane %0d but not outstanding",
                                           cdb_tag[c], c));
                    assert (cdb_value[c] == exp_val[cdb_tag[c]]) else
                        fail_run($sformatf("** Error: cdb_value[%0d] = 0x%08h, expected 0x%08h",
                                           c, cdb_value[c], exp_val[cdb_tag[c]]));
                    tag_state[cdb_tag[c]] = ST_FREE;   // Tag free for reuse
                    n_bcast++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int                 t;
        int                 p;
        int                 k;
        int                 n;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        seed     = 99;
        next_tag = 0;
        n_disp   = 0;
        n_drop   = 0;
        n_bcast  = 0;
        for (int i = 0; i < NTAG; i++) begin
            exp_val[i]   = '0;
            tag_state[i] = ST_FREE;
        end
        rst_n            = 1'b0;
        flush            = 1'b0;
        alloc_valid      = '0;
        alloc_dest_tag   = '0;
        alloc_src1_ready = '0;
        alloc_src1_tag   = '0;
        alloc_src1_value = '0;
        alloc_src2_ready = '0;
        alloc_src2_tag   = '0;
        alloc_src2_value = '0;
        for (int l = 0; l < `N_DISPATCH; l++) alloc_op[l] = ALU_ADD;
        repeat (5) @(posedge clock);
        #1;
        rst_n = 1'b1;

        // Reset state
        assert (cdb_valid == '0) else
            fail_run($sformatf("** Error: cdb_valid = 0x%0h, expected 0x0", cdb_valid));
        check_free_count(2);

        // Independent pairs over every opcode
        for (int i = 0; i < 12; i += 2) begin
            wait_space(2);
            for (int l = 0; l < 2; l++) begin
                take_tag(t);
                stage_lane(l, alu_op_e'((i + l) % 6), -1, $random(seed), -1, $random(seed), t);
            end
            commit();
        end
        wait_idle();

        // Back-to-back chain
        dispatch_one(ALU_ADD, -1, $random(seed), -1, $random(seed), p);
        for (int i = 0; i < 5; i++) begin
            dispatch_one(alu_op_e'(i % 6), p, '0, -1, $random(seed), t);
            p = t;
        end
        // Consumer arrives while its producer is on the bus
        for (int i = 0; i < 3; i++) begin
            dispatch_one(ALU_XOR, -1, $random(seed), -1, $random(seed), p);
            wait_on_bus(p);
            dispatch_one(ALU_ADD, p, '0, p, '0, t);
        end
        wait_space(2);                     // Lane 1 waits on lane 0 of the same cycle
        take_tag(p);
        stage_lane(0, ALU_OR, -1, $random(seed), -1, $random(seed), p);
        take_tag(t);
        stage_lane(1, ALU_SLL, p, '0, -1, 32'd3, t);
        commit();
        wait_idle();

        // Back-pressure with the producer result planned before its consumers
        a = $random(seed);
        b = $random(seed);
        take_tag(p);
        exp_val[p]   = alu_model(ALU_ADD, a, b);
        tag_state[p] = ST_OUT;
        for (int i = 0; i < 3; i++) begin
            wait_space(2);
            for (int l = 0; l < 2; l++) begin
                take_tag(t);
                stage_lane(l, alu_op_e'(rnd(6)), p, '0, -1, $random(seed), t);
            end
            commit();
        end
        wait_space(2);
        take_tag(t);
        stage_lane(0, ALU_AND, p, '0, p, '0, t);
        stage_lane(1, ALU_ADD, -1, a, -1, b, p);   // Producer takes the last slot
        commit();
        check_free_count(0);
        dispatch_one(ALU_OR, -1, $random(seed), -1, $random(seed), t);   // Stalls for a slot
        wait_idle();
        wait_free_count(2);

        // Flush with waiters on a tag that never comes
        take_tag(p);
        exp_val[p]   = '0;
        tag_state[p] = ST_OUT;
        n_disp++;
        for (int i = 0; i < 3; i++) begin
            wait_space(2);
            for (int l = 0; l < 2; l++) begin
                take_tag(t);
                stage_lane(l, ALU_XOR, p, '0, -1, $random(seed), t);
            end
            commit();
        end
        wait_space(2);
        take_tag(t);
        stage_lane(0, ALU_XOR, p, '0, -1, $random(seed), t);
        take_tag(t);
        stage_lane(1, ALU_ADD, -1, $random(seed), -1, $random(seed), t);  // In the ALU at flush
        commit();
        check_free_count(0);               // Station full of waiters
        flush = 1'b1;
        step();
        flush = 1'b0;
        for (int i = 0; i < NTAG; i++) begin
            if (tag_state[i] == ST_OUT) begin
                tag_state[i] = ST_DROP;
                n_drop++;
            end
        end
        check_free_count(2);
        repeat (20) step();                // Monitor rejects any dropped tag
        for (int i = 0; i < NTAG; i++) begin
            if (tag_state[i] == ST_DROP) tag_state[i] = ST_FREE;
        end

        // Random mixed stream
        n = 0;
        while (n < 200) begin
            k = 1 + rnd(2);
            if (k > 200 - n) k = 200 - n;
            wait_space(k);
            for (int l = 0; l < k; l++) begin
                take_tag(t);
                stage_lane(l, alu_op_e'(rnd(6)), pick_src(), $random(seed),
                           pick_src(), $random(seed), t);
                recent.push_back(t);
                if (recent.size() > 6) void'(recent.pop_front());
                n++;
            end
            commit();
            if (rnd(4) == 0) step();       // Idle gap
        end
        wait_idle();
        wait_free_count(2);

        // Each surviving tag went out once
        assert (n_bcast == n_disp - n_drop) else
            fail_run($sformatf("Broadcast count %0d does not match %0d surviving instructions",
                               n_bcast, n_disp - n_drop));
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- ooo_issue.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/rs_pkg.sv
verilog/rs_free_select.sv
verilog/rs.sv
verilog/issue_select.sv
verilog/alu_unit.sv
verilog/ooo_issue_core.sv
test/tb_ooo_issue_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the issue stage testbench with Verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_ooo_issue_core
BUILD_DIR=obj_dir

# Warnings still print, they just do not stop the build
verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -f ooo_issue.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

# Any failing check ends in \$fatal, so the exit status carries the result
"./$BUILD_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit "$status"
fi

exit 0
